/* cdcFifoFlops.f */
design/fifoCfgPkg.sv
design/grayPtrPkg.sv
design/grayPtrSync.sv
design/pushCtrl.sv
design/flopRam.sv
design/popCtrl.sv
design/cdcFifoFlops.sv
verification/cdcFifoFlops_sva.sv
verification/cdcFifoFlopsTb.sv

/* design/cdcFifoFlops.sv */
// Top level of the asynchronous FIFO with internal flop storage.
// Producer logic on pushClk and consumer logic on popClk connect here
// through valid/ready ports; arstN resets both domains together.

`timescale 1ns/10ps

module cdcFifoFlops
  import fifoCfgPkg::*;
  import grayPtrPkg::*;
(
  input  logic                  pushClk,
  input  logic                  popClk,
  input  logic                  arstN,
  input  logic                  pushValid,
  input  dataT                  pushData,
  output logic                  pushReady,
  output logic                  pushFull,
  output logic [countWidth-1:0] pushSlots,
  input  logic                  popReady,
  output logic                  popValid,
  output logic                  popEmpty,
  output dataT                  popData,
  output logic [countWidth-1:0] popItems
);

  // ---------------------------------------------------------------------------
  // Internal wiring
  // ---------------------------------------------------------------------------

  // RAM write port, driven in the push domain.
  logic                 ramWrEn;
  logic [addrWidth-1:0] ramWrAddr;
  dataT                 ramWrData;

  // RAM read port, addressed from the pop domain.
  logic [addrWidth-1:0] ramRdAddr;
  dataT                 ramRdData;

  // Gray pointers crossing between the domains.
  ptrT wrPtrGray;
  ptrT rdPtrGray;

  pushCtrl pushCtrl_inst (
    .pushClk   (pushClk),
    .arstN     (arstN),
    .pushValid (pushValid),
    .pushData  (pushData),
    .rdPtrGray (rdPtrGray),
    .pushReady (pushReady),
    .pushFull  (pushFull),
    .pushSlots (pushSlots),
    .ramWrEn   (ramWrEn),
    .ramWrAddr (ramWrAddr),
    .ramWrData (ramWrData),
    .wrPtrGray (wrPtrGray)
  );

  flopRam flopRam_inst (
    .pushClk   (pushClk),
    .ramWrEn   (ramWrEn),
    .ramWrAddr (ramWrAddr),
    .ramWrData (ramWrData),
    .ramRdAddr (ramRdAddr),
    .ramRdData (ramRdData)
  );

  popCtrl popCtrl_inst (
    .popClk    (popClk),
    .arstN     (arstN),
    .popReady  (popReady),
    .wrPtrGray (wrPtrGray),
    .ramRdData (ramRdData),
    .popValid  (popValid),
    .popEmpty  (popEmpty),
    .popData   (popData),
    .popItems  (popItems),
    .ramRdAddr (ramRdAddr),
    .rdPtrGray (rdPtrGray)
  );

endmodule

/* design/fifoCfgPkg.sv */
// Geometry of the clock-domain-crossing FIFO and its data word.
// Every RTL file and the testbench import these constants, so one edit
// here resizes the whole FIFO.

package fifoCfgPkg;

  // ---------------------------------------------------------------------------
  // Geometry
  // ---------------------------------------------------------------------------

  // Number of RAM entries. It must be a power of two so that the
  // Gray-coded pointers wrap cleanly.
  localparam int fifoDepth = 8;

  // Width of one data word in bits.
  localparam int dataWidth = 16;

  // Number of flops in each pointer synchronizer chain.
  localparam int syncStages = 2;

  // Bits needed to address one RAM entry.
  localparam int addrWidth = $clog2(fifoDepth);

  // Bits needed to hold a count from zero up to fifoDepth and one more.
  localparam int countWidth = addrWidth + 1;

  // One data word as it travels from the push port to the pop port.
  typedef logic [dataWidth-1:0] dataT;

endpackage

/* design/flopRam.sv */
// Flop storage of the CDC FIFO.
// Words are written on pushClk, and the pop domain reads one entry by
// address without any clock of its own on the read side.

`timescale 1ns/10ps

module flopRam
  import fifoCfgPkg::*;
(
  input  logic                 pushClk,
  input  logic                 ramWrEn,
  input  logic [addrWidth-1:0] ramWrAddr,
  input  dataT                 ramWrData,
  input  logic [addrWidth-1:0] ramRdAddr,
  output dataT                 ramRdData
);

  // ---------------------------------------------------------------------------
  // Storage
  // ---------------------------------------------------------------------------

  // One word per FIFO entry.
  // An entry is always written before the pop side may address it.
  dataT mem [fifoDepth];

  // Write port in the push domain.
  always_ff @(posedge pushClk) begin
    if (ramWrEn) begin
      mem[ramWrAddr] <= ramWrData;
    end
  end

  // ---------------------------------------------------------------------------
  // Read port
  // ---------------------------------------------------------------------------

  // The addressed entry goes straight out.
  // The pop side only addresses entries whose write pointer update has
  // already crossed the synchronizer, so the word is long stable when
  // popCtrl samples it.
  assign ramRdData = mem[ramRdAddr];

endmodule

/* design/grayPtrPkg.sv */
// Pointer type and Gray-code helpers shared by both FIFO domains.
// A pointer carries one wrap bit above the RAM address, which lets
// full and empty be told apart when the addresses are equal.

package grayPtrPkg;

  import fifoCfgPkg::*;

  // Read or write pointer: the address bits plus the wrap bit on top.
  typedef logic [addrWidth:0] ptrT;

  // Converts a binary pointer to Gray code.
  // Consecutive values then differ in exactly one bit.
  function automatic ptrT binToGray(ptrT bin);
    return bin ^ (bin >> 1);
  endfunction

  // Converts a Gray-coded pointer back to binary.
  // Each binary bit is the XOR of all Gray bits at or above it, so the
  // result is built from the top down.
  function automatic ptrT grayToBin(ptrT gray);
    ptrT bin;
    bin[addrWidth] = gray[addrWidth];
    for (int i = addrWidth - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* design/grayPtrSync.sv */
// Multi-flop synchronizer for a Gray-coded FIFO pointer.
// The pointer enters from the other clock domain and leaves syncStages
// edges of clk later; an instance sits in each FIFO controller.

`timescale 1ns/10ps

module grayPtrSync
  import fifoCfgPkg::*;
  import grayPtrPkg::*;
(
  input  logic clk,
  input  logic arstN,
  input  ptrT  ptrIn,
  output ptrT  ptrOut
);

  // Synchronizer chain. Entry 0 samples the foreign pointer.
  ptrT syncQ [syncStages];

  // Only one bit of a Gray pointer moves per step, so a flop that goes
  // metastable settles to either the old or the new pointer.
  // Both are real pointer values, and the receiving side stays correct.
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      syncQ <= '{default: '0};
    end else begin
      syncQ[0] <= ptrIn;
      for (int i = 1; i < syncStages; i++) begin
        syncQ[i] <= syncQ[i-1];
      end
    end
  end

  // The last stage is the settled pointer seen by the local domain.
  assign ptrOut = syncQ[syncStages-1];

endmodule

/* design/popCtrl.sv */
// Pop-domain control of the CDC FIFO.
// It moves the oldest visible word from the RAM into the pop output
// register, publishes the Gray read pointer and reports the item count.

`timescale 1ns/10ps

module popCtrl
  import fifoCfgPkg::*;
  import grayPtrPkg::*;
(
  input  logic                  popClk,
  input  logic                  arstN,
  input  logic                  popReady,
  input  ptrT                   wrPtrGray,
  input  dataT                  ramRdData,
  output logic                  popValid,
  output logic                  popEmpty,
  output dataT                  popData,
  output logic [countWidth-1:0] popItems,
  output logic [addrWidth-1:0]  ramRdAddr,
  output ptrT                   rdPtrGray
);

  // ---------------------------------------------------------------------------
  // Reset release
  // ---------------------------------------------------------------------------

  // Two-flop reset synchronizer on popClk.
  // This domain leaves reset independently of the push side.
  logic [1:0] rstSync;
  logic       popRstN;

  always_ff @(posedge popClk or negedge arstN) begin
    if (!arstN) begin
      rstSync <= 2'b00;
    end else begin
      rstSync <= {rstSync[0], 1'b1};
    end
  end

  assign popRstN = rstSync[1];

  // ---------------------------------------------------------------------------
  // Write pointer view
  // ---------------------------------------------------------------------------

  ptrT wrPtrSync;
  ptrT wrPtrBin;
  ptrT rdPtrBin;
  ptrT visCount;

  grayPtrSync wrPtrSync_inst (
    .clk    (popClk),
    .arstN  (popRstN),
    .ptrIn  (wrPtrGray),
    .ptrOut (wrPtrSync)
  );

  assign wrPtrBin = grayToBin(wrPtrSync);

  // Words written to the RAM and already visible here, not yet moved out.
  assign visCount = wrPtrBin - rdPtrBin;

  // ---------------------------------------------------------------------------
  // Output register
  // ---------------------------------------------------------------------------

  logic outFree;
  logic outLoad;

  // The output register can take a word when it is empty or drains now.
  assign outFree = !popValid || popReady;
  assign outLoad = outFree && (visCount != '0);

  // The head of the RAM is always the entry at the read pointer.
  assign ramRdAddr = rdPtrBin[addrWidth-1:0];

  // Valid holds under back-pressure and otherwise follows availability.
  always_ff @(posedge popClk or negedge popRstN) begin
    if (!popRstN) begin
      popValid <= 1'b0;
    end else if (outFree) begin
      popValid <= (visCount != '0);
    end
  end

  // Payload register. It only changes on a load, so data is stable while
  // the consumer stalls.
  always_ff @(posedge popClk) begin
    if (outLoad) begin
      popData <= ramRdData;
    end
  end

  // Each move frees one RAM entry. The Gray copy tells the push side.
  always_ff @(posedge popClk or negedge popRstN) begin
    if (!popRstN) begin
      rdPtrBin  <= '0;
      rdPtrGray <= '0;
    end else if (outLoad) begin
      rdPtrBin  <= rdPtrBin + 1'b1;
      rdPtrGray <= binToGray(rdPtrBin + 1'b1);
    end
  end

  // ---------------------------------------------------------------------------
  // Status
  // ---------------------------------------------------------------------------

  // Items count the visible RAM words plus the one in the output register.
  assign popItems = countWidth'(visCount) + countWidth'(popValid);
  assign popEmpty = (popItems == '0);

endmodule

/* design/pushCtrl.sv */
// Push-domain control of the CDC FIFO.
// It accepts words on the valid/ready push port, writes them to the RAM,
// publishes the Gray write pointer and reports the free-slot count.

`timescale 1ns/10ps

module pushCtrl
  import fifoCfgPkg::*;
  import grayPtrPkg::*;
(
  input  logic                  pushClk,
  input  logic                  arstN,
  input  logic                  pushValid,
  input  dataT                  pushData,
  input  ptrT                   rdPtrGray,
  output logic                  pushReady,
  output logic                  pushFull,
  output logic [countWidth-1:0] pushSlots,
  output logic                  ramWrEn,
  output logic [addrWidth-1:0]  ramWrAddr,
  output dataT                  ramWrData,
  output ptrT                   wrPtrGray
);

  // ---------------------------------------------------------------------------
  // Reset release
  // ---------------------------------------------------------------------------

  // Two-flop reset synchronizer. Reset asserts at once and releases on
  // the second pushClk edge after arstN rises.
  logic [1:0] rstSync;
  logic       pushRstN;

  always_ff @(posedge pushClk or negedge arstN) begin
    if (!arstN) begin
      rstSync <= 2'b00;
    end else begin
      rstSync <= {rstSync[0], 1'b1};
    end
  end

  assign pushRstN = rstSync[1];

  // ---------------------------------------------------------------------------
  // Write pointer
  // ---------------------------------------------------------------------------

  ptrT wrPtrBin;
  logic pushAccept;

  // A word transfers when the producer offers it and a slot is free.
  assign pushAccept = pushValid && pushReady;

  // The binary pointer addresses the RAM.
  // The Gray copy is registered so the other domain never sees glitches.
  always_ff @(posedge pushClk or negedge pushRstN) begin
    if (!pushRstN) begin
      wrPtrBin  <= '0;
      wrPtrGray <= '0;
    end else if (pushAccept) begin
      wrPtrBin  <= wrPtrBin + 1'b1;
      wrPtrGray <= binToGray(wrPtrBin + 1'b1);
    end
  end

  // The write lands in the RAM at the same edge that advances the pointer.
  assign ramWrEn   = pushAccept;
  assign ramWrAddr = wrPtrBin[addrWidth-1:0];
  assign ramWrData = pushData;

  // ---------------------------------------------------------------------------
  // Read pointer view and status
  // ---------------------------------------------------------------------------

  ptrT rdPtrSync;
  ptrT rdPtrBin;
  ptrT usedCount;

  grayPtrSync rdPtrSync_inst (
    .clk    (pushClk),
    .arstN  (pushRstN),
    .ptrIn  (rdPtrGray),
    .ptrOut (rdPtrSync)
  );

  assign rdPtrBin = grayToBin(rdPtrSync);

  // The read pointer seen here lags the pop domain.
  // Slots are therefore never overstated, only freed a little late.
  assign usedCount = wrPtrBin - rdPtrBin;
  assign pushSlots = countWidth'(fifoDepth) - countWidth'(usedCount);
  assign pushFull  = (pushSlots == '0);

  // Ready follows the registered reset release and the slot count.
  assign pushReady = pushRstN && !pushFull;

endmodule

/* verification/cdcFifoFlopsTb.sv */
// Testbench for the CDC FIFO with flop storage.
// It runs reset, push-only, pop-only and mixed random traffic on two
// drifting clocks and checks every popped word against a reference queue.

`timescale 1ns/10ps

module cdcFifoFlopsTb
  import fifoCfgPkg::*;
();

  logic                  pushClk;
  logic                  popClk;
  logic                  arstN;
  logic                  pushValid;
  dataT                  pushData;
  logic                  pushReady;
  logic                  pushFull;
  logic [countWidth-1:0] pushSlots;
  logic                  popReady;
  logic                  popValid;
  logic                  popEmpty;
  dataT                  popData;
  logic [countWidth-1:0] popItems;

  // Words accepted on the push port, oldest first.
  dataT        refQ [$];
  dataT        expWord;
  logic [31:0] lfsrState;
  int          popMode;
  int          mismatchErrs;
  int          otherErrs;
  int          totalErrs;
  int          fillCount;
  int          idle;
  int          cycles;
  logic        took;

  cdcFifoFlops cdcFifoFlops_inst (.*);

  // The periods share no small multiple, so the two domains drift in phase.
  always #10 pushClk = ~pushClk;
  always #17 popClk = ~popClk;

  // Galois LFSR, one step per bit taken.
  function automatic logic takeBit();
    lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
    return lfsrState[0];
  endfunction

  function automatic dataT randWord();
    dataT w;
    for (int i = 0; i < dataWidth; i++) begin
      w[i] = takeBit();
    end
    return w;
  endfunction

  task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      mismatchErrs++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // Waits for the FIFO to run dry and for the push side to see every slot free.
  task automatic drainAll(string phase);
    int n;
    n = 0;
    while (popItems != 0 && n < 300) begin
      @(posedge popClk);
      #2;
      n++;
    end
    if (popItems != 0) begin
      otherErrs++;
      $display("Timeout: the FIFO did not drain during the %s phase", phase);
    end
    // Once empty, nothing may appear on the pop port.
    repeat (4) begin
      @(posedge popClk);
      #2;
      checkValue("popValid", popValid, 0);
      checkValue("popEmpty", popEmpty, 1);
    end
    n = 0;
    while (pushSlots != fifoDepth && n < 50) begin
      @(posedge pushClk);
      #2;
      n++;
    end
    assert (pushSlots == fifoDepth) else begin
      otherErrs++;
      $display("Timeout: pushSlots stayed at %0d instead of %0d after the %s phase",
               pushSlots, fifoDepth, phase);
    end
    assert (refQ.size() == 0) else begin
      otherErrs++;
      $display("Reference queue still holds %0d words after %s", refQ.size(), phase);
    end
  endtask

  task automatic checkResetState();
    checkValue("pushReady", pushReady, 0);
    checkValue("pushFull", pushFull, 0);
    checkValue("popValid", popValid, 0);
    checkValue("popEmpty", popEmpty, 1);
    checkValue("pushSlots", pushSlots, fifoDepth);
    checkValue("popItems", popItems, 0);
  endtask

  // ----------------------------------------------------------------------
  // Monitors and status checks
  // ----------------------------------------------------------------------

  always @(posedge pushClk) begin
    if (pushValid && pushReady) begin
      refQ.push_back(pushData);
    end
  end

  always @(posedge popClk) begin
    if (popValid && popReady) begin
      if (refQ.size() == 0) begin
        otherErrs++;
        $display("A word was popped that was never pushed, at %0t", $time);
      end else begin
        expWord = refQ.pop_front();
        checkValue("popData", popData, expWord);
      end
    end
  end

  // Consumer. Mode 0 stalls, mode 1 takes every word, mode 2 is random.
  always @(posedge popClk) begin
    #2;
    if (popMode == 1) begin
      popReady = 1'b1;
    end else if (popMode == 2) begin
      popReady = takeBit();
    end else begin
      popReady = 1'b0;
    end
  end

  fullFlagA: assert property (@(posedge pushClk) disable iff (!arstN)
    pushFull == (pushSlots == 0))
    else begin
      mismatchErrs++;
      $display("Mismatch at %0t: pushFull got %0b expected %0b", $time,
               $sampled(pushFull), $sampled(pushSlots) == 0);
    end

  emptyFlagA: assert property (@(posedge popClk) disable iff (!arstN)
    popEmpty == (popItems == 0))
    else begin
      mismatchErrs++;
      $display("Mismatch at %0t: popEmpty got %0b expected %0b", $time,
               $sampled(popEmpty), $sampled(popItems) == 0);
    end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  initial begin
    pushClk = 1'b0;
    popClk = 1'b0;
    arstN = 1'b0;
    pushValid = 1'b0;
    pushData = '0;
    popReady = 1'b0;
    popMode = 0;
    lfsrState = 32'h19b5_0a10;
    mismatchErrs = 0;
    otherErrs = 0;

    // Reset is checked halfway through and again just after it is released.
    repeat (8) @(posedge pushClk);
    #2;
    checkResetState();
    repeat (8) @(posedge pushClk);
    #2;
    arstN = 1'b1;
    checkResetState();
    repeat (6) @(posedge pushClk);

    // Push-only. With the consumer stalled, the RAM plus the output
    // register take fifoDepth + 1 words before the push side closes.
    #2;
    pushValid = 1'b1;
    pushData = randWord();
    fillCount = 0;
    idle = 0;
    cycles = 0;
    while (idle < 30 && cycles < 400) begin
      @(posedge pushClk);
      took = pushReady;
      #2;
      cycles++;
      if (took) begin
        fillCount++;
        idle = 0;
        pushData = randWord();
      end else begin
        idle++;
      end
    end
    pushValid = 1'b0;
    if (idle < 30) begin
      otherErrs++;
      $display("Timeout: the push side never stopped accepting while stalled");
    end
    checkValue("accepted pushes", fillCount, fifoDepth + 1);
    checkValue("pushFull", pushFull, 1);
    checkValue("pushSlots", pushSlots, 0);
    checkValue("pushReady", pushReady, 0);
    @(posedge popClk);
    #2;
    checkValue("popValid", popValid, 1);
    checkValue("popItems", popItems, fifoDepth + 1);

    // Pop-only.
    popMode = 1;
    drainAll("pop-only");

    // Mixed traffic. A word stays on the push port until it is taken.
    popMode = 2;
    @(posedge pushClk);
    for (int c = 0; c < 1500; c++) begin
      @(posedge pushClk);
      took = pushValid && pushReady;
      #2;
      if (took || !pushValid) begin
        pushValid = takeBit();
        pushData = randWord();
      end
    end
    pushValid = 1'b0;
    popMode = 1;
    drainAll("mixed");

    totalErrs = mismatchErrs + otherErrs + cdcFifoFlops_inst.cdcFifoFlops_sva_inst.failCount;
    $display("Error counts: mismatch %0d, other %0d, bound assertion %0d", mismatchErrs,
             otherErrs, cdcFifoFlops_inst.cdcFifoFlops_sva_inst.failCount);
    if (totalErrs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Overall limit on the run, well beyond the normal length.
  initial begin
    #2_000_000;
    $display("Timeout: the run did not reach its end in time");
    $display("Regression failed");
    $finish;
  end

endmodule

/* verification/cdcFifoFlops_sva.sv */
// Protocol assertions for the CDC FIFO ports.
// The module is bound into every cdcFifoFlops instance. It only watches
// the ports and keeps a count of failed assertions for the testbench.

`timescale 1ns/10ps

module cdcFifoFlops_sva
  import fifoCfgPkg::*;
(
  input logic                  pushClk,
  input logic                  popClk,
  input logic                  arstN,
  input logic                  pushReady,
  input logic                  pushFull,
  input logic [countWidth-1:0] pushSlots,
  input logic                  popReady,
  input logic                  popValid,
  input logic                  popEmpty,
  input dataT                  popData,
  input logic [countWidth-1:0] popItems
);

  int failCount = 0;

  // A stalled pop word must stay on the port, unchanged, until it is taken.
  popHoldA: assert property (@(posedge popClk) disable iff (!arstN)
    popValid && !popReady |=> popValid && $stable(popData))
    else begin failCount++; $error("Pop word changed under back-pressure"); end

  // A full FIFO never offers a free slot.
  fullNotReadyA: assert property (@(posedge pushClk) disable iff (!arstN)
    pushFull |-> !pushReady)
    else begin failCount++; $error("pushReady high while pushFull is set"); end

  // An empty FIFO never presents a word.
  emptyNotValidA: assert property (@(posedge popClk) disable iff (!arstN)
    popEmpty |-> !popValid)
    else begin failCount++; $error("popValid high while popEmpty is set"); end

  // The push side never sees more free slots than RAM entries.
  slotsBoundA: assert property (@(posedge pushClk) pushSlots <= fifoDepth)
    else begin failCount++; $error("pushSlots above the FIFO depth"); end

  // The pop side holds at most the RAM plus the output register.
  itemsBoundA: assert property (@(posedge popClk) popItems <= fifoDepth + 1)
    else begin failCount++; $error("popItems above the FIFO capacity"); end

endmodule

bind cdcFifoFlops cdcFifoFlops_sva cdcFifoFlops_sva_inst (.*);
